// ==== source/cu_pkg.sv ====
`default_nettype none

package cu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Field types
    ////////////////////////////////////////////////////////////////////////////

    // Upper five and lower two bits of the instruction, joined
    typedef logic [6:0] opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_ADDC = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SUBC = 4'd3,
        ALU_CMP  = 4'd4,
        ALU_AND  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_EXOR = 4'd7,
        ALU_TEST = 4'd8,
        ALU_LSL  = 4'd9,
        ALU_LSR  = 4'd10,
        ALU_ROL  = 4'd11,
        ALU_ROR  = 4'd12,
        ALU_ASR  = 4'd13,
        ALU_MOV  = 4'd14
    } alu_op_t;

    typedef enum logic [1:0] {
        PC_IMM   = 2'd0,
        PC_STACK = 2'd1,
        PC_INTR  = 2'd2
    } pc_src_t;

    typedef enum logic [1:0] {
        SCR_REG   = 2'd0,
        SCR_IMM   = 2'd1,
        SCR_SP    = 2'd2,
        SCR_SP_M1 = 2'd3
    } scr_addr_t;

    // Codes 2 and 3 unused
    typedef enum logic [1:0] {
        RF_ALU = 2'd0,
        RF_SCR = 2'd1
    } rf_src_t;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath control word
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic      pc_ld;
        logic      pc_inc;
        pc_src_t   pc_src;
        logic      alu_opy_imm;
        alu_op_t   alu_op;
        logic      rf_wr;
        rf_src_t   rf_src;
        logic      sp_ld;
        logic      sp_incr;
        logic      sp_decr;
        logic      scr_we;
        logic      scr_data_pc;
        scr_addr_t scr_addr;
        logic      flg_c_set;
        logic      flg_c_clr;
        logic      flg_c_ld;
        logic      flg_z_ld;
        logic      flg_ld_shadow;
        logic      flg_shad_ld;
        logic      i_set;
        logic      i_clr;
        logic      rst;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_NONE = ctrl_word_t'('0);

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////////////////////

    localparam opcode_t OP_AND   = 7'b000_0000;
    localparam opcode_t OP_OR    = 7'b000_0001;
    localparam opcode_t OP_EXOR  = 7'b000_0010;
    localparam opcode_t OP_TEST  = 7'b000_0011;
    localparam opcode_t OP_ADD   = 7'b000_0100;
    localparam opcode_t OP_ADDC  = 7'b000_0101;
    localparam opcode_t OP_SUB   = 7'b000_0110;
    localparam opcode_t OP_SUBC  = 7'b000_0111;
    localparam opcode_t OP_CMP   = 7'b000_1000;
    localparam opcode_t OP_MOV   = 7'b000_1001;
    localparam opcode_t OP_LD    = 7'b000_1010;
    localparam opcode_t OP_ST    = 7'b000_1011;
    localparam opcode_t OP_BRN   = 7'b001_0000;
    localparam opcode_t OP_CALL  = 7'b001_0001;
    localparam opcode_t OP_BREQ  = 7'b001_0010;
    localparam opcode_t OP_BRNE  = 7'b001_0011;
    localparam opcode_t OP_BRCS  = 7'b001_0100;
    localparam opcode_t OP_BRCC  = 7'b001_0101;
    localparam opcode_t OP_LSL   = 7'b010_0000;
    localparam opcode_t OP_LSR   = 7'b010_0001;
    localparam opcode_t OP_ROL   = 7'b010_0010;
    localparam opcode_t OP_ROR   = 7'b010_0011;
    localparam opcode_t OP_ASR   = 7'b010_0100;
    localparam opcode_t OP_PUSH  = 7'b010_0101;
    localparam opcode_t OP_POP   = 7'b010_0110;
    localparam opcode_t OP_WSP   = 7'b010_1000;
    localparam opcode_t OP_CLC   = 7'b011_0000;
    localparam opcode_t OP_SEC   = 7'b011_0001;
    localparam opcode_t OP_RET   = 7'b011_0010;
    localparam opcode_t OP_SEI   = 7'b011_0100;
    localparam opcode_t OP_CLI   = 7'b011_0101;
    localparam opcode_t OP_RETID = 7'b011_0110;
    localparam opcode_t OP_RETIE = 7'b011_0111;

    // Immediate families whose low two opcode bits belong to the immediate
    localparam logic [4:0] IMM_AND  = 5'b10000;
    localparam logic [4:0] IMM_OR   = 5'b10001;
    localparam logic [4:0] IMM_EXOR = 5'b10010;
    localparam logic [4:0] IMM_TEST = 5'b10011;
    localparam logic [4:0] IMM_ADD  = 5'b10100;
    localparam logic [4:0] IMM_ADDC = 5'b10101;
    localparam logic [4:0] IMM_SUB  = 5'b10110;
    localparam logic [4:0] IMM_SUBC = 5'b10111;
    localparam logic [4:0] IMM_CMP  = 5'b11000;
    localparam logic [4:0] IMM_MOV  = 5'b11011;
    localparam logic [4:0] IMM_LD   = 5'b11100;
    localparam logic [4:0] IMM_ST   = 5'b11101;

endpackage

`default_nettype wire

// ==== source/ctrl_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_decode (
    input  cu_pkg::opcode_t    opcode,
    input  logic               c,
    input  logic               z,
    output cu_pkg::ctrl_word_t exec_ctrl,
    output logic               illegal
);
    import cu_pkg::*;

    // Common word for every ALU instruction
    function automatic ctrl_word_t alu_ctrl(input alu_op_t op, input logic imm);
        ctrl_word_t w;
        w             = CTRL_NONE;
        w.alu_op      = op;
        w.alu_opy_imm = imm;
        w.rf_wr       = (op != ALU_CMP) && (op != ALU_TEST);
        case (op)
            ALU_AND, ALU_OR, ALU_EXOR, ALU_TEST: begin
                w.flg_c_clr = 1'b1;
                w.flg_z_ld  = 1'b1;
            end
            ALU_MOV: begin
                // Mov leaves the flags alone
            end
            default: begin
                w.flg_c_ld = 1'b1;
                w.flg_z_ld = 1'b1;
            end
        endcase
        return w;
    endfunction

    always_comb begin
        exec_ctrl = CTRL_NONE;
        illegal   = 1'b0;

        case (opcode)
            ////////////////////////////////////////////////////////////////////////
            // Register-register ALU, shifts and rotates
            ////////////////////////////////////////////////////////////////////////
            OP_AND:  exec_ctrl = alu_ctrl(ALU_AND, 1'b0);
            OP_OR:   exec_ctrl = alu_ctrl(ALU_OR, 1'b0);
            OP_EXOR: exec_ctrl = alu_ctrl(ALU_EXOR, 1'b0);
            OP_TEST: exec_ctrl = alu_ctrl(ALU_TEST, 1'b0);
            OP_ADD:  exec_ctrl = alu_ctrl(ALU_ADD, 1'b0);
            OP_ADDC: exec_ctrl = alu_ctrl(ALU_ADDC, 1'b0);
            OP_SUB:  exec_ctrl = alu_ctrl(ALU_SUB, 1'b0);
            OP_SUBC: exec_ctrl = alu_ctrl(ALU_SUBC, 1'b0);
            OP_CMP:  exec_ctrl = alu_ctrl(ALU_CMP, 1'b0);
            OP_MOV:  exec_ctrl = alu_ctrl(ALU_MOV, 1'b0);
            OP_LSL:  exec_ctrl = alu_ctrl(ALU_LSL, 1'b0);
            OP_LSR:  exec_ctrl = alu_ctrl(ALU_LSR, 1'b0);
            OP_ROL:  exec_ctrl = alu_ctrl(ALU_ROL, 1'b0);
            OP_ROR:  exec_ctrl = alu_ctrl(ALU_ROR, 1'b0);
            OP_ASR:  exec_ctrl = alu_ctrl(ALU_ASR, 1'b0);

            ////////////////////////////////////////////////////////////////////////
            // Branches and call
            ////////////////////////////////////////////////////////////////////////
            OP_BRN:  exec_ctrl.pc_ld = 1'b1;
            OP_BREQ: exec_ctrl.pc_ld = z;
            OP_BRNE: exec_ctrl.pc_ld = ~z;
            OP_BRCS: exec_ctrl.pc_ld = c;
            OP_BRCC: exec_ctrl.pc_ld = ~c;
            OP_CALL: begin
                // Return address goes below the stack pointer
                exec_ctrl.pc_ld       = 1'b1;
                exec_ctrl.sp_decr     = 1'b1;
                exec_ctrl.scr_we      = 1'b1;
                exec_ctrl.scr_data_pc = 1'b1;
                exec_ctrl.scr_addr    = SCR_SP_M1;
            end

            ////////////////////////////////////////////////////////////////////////
            // Stack and scratch RAM
            ////////////////////////////////////////////////////////////////////////
            OP_LD: begin
                exec_ctrl.rf_wr    = 1'b1;
                exec_ctrl.rf_src   = RF_SCR;
                exec_ctrl.scr_addr = SCR_REG;
            end
            OP_ST: begin
                exec_ctrl.scr_we   = 1'b1;
                exec_ctrl.scr_addr = SCR_REG;
            end
            OP_PUSH: begin
                exec_ctrl.sp_decr  = 1'b1;
                exec_ctrl.scr_we   = 1'b1;
                exec_ctrl.scr_addr = SCR_SP_M1;
            end
            OP_POP: begin
                exec_ctrl.sp_incr  = 1'b1;
                exec_ctrl.scr_addr = SCR_SP;
                exec_ctrl.rf_wr    = 1'b1;
                exec_ctrl.rf_src   = RF_SCR;
            end
            OP_WSP: exec_ctrl.sp_ld = 1'b1;

            OP_RET, OP_RETID, OP_RETIE: begin
                exec_ctrl.pc_ld    = 1'b1;
                exec_ctrl.pc_src   = PC_STACK;
                exec_ctrl.sp_incr  = 1'b1;
                exec_ctrl.scr_addr = SCR_SP;
                if (opcode != OP_RET) begin
                    // Flags come back from the shadow copy
                    exec_ctrl.flg_ld_shadow = 1'b1;
                    exec_ctrl.flg_c_ld      = 1'b1;
                    exec_ctrl.flg_z_ld      = 1'b1;
                end
                exec_ctrl.i_set = (opcode == OP_RETIE);
                exec_ctrl.i_clr = (opcode == OP_RETID);
            end

            ////////////////////////////////////////////////////////////////////////
            // Flag and interrupt enable
            ////////////////////////////////////////////////////////////////////////
            OP_SEC: exec_ctrl.flg_c_set = 1'b1;
            OP_CLC: exec_ctrl.flg_c_clr = 1'b1;
            OP_SEI: exec_ctrl.i_set     = 1'b1;
            OP_CLI: exec_ctrl.i_clr     = 1'b1;

            default: begin
                // Immediate forms
                case (opcode[6:2])
                    IMM_AND:  exec_ctrl = alu_ctrl(ALU_AND, 1'b1);
                    IMM_OR:   exec_ctrl = alu_ctrl(ALU_OR, 1'b1);
                    IMM_EXOR: exec_ctrl = alu_ctrl(ALU_EXOR, 1'b1);
                    IMM_TEST: exec_ctrl = alu_ctrl(ALU_TEST, 1'b1);
                    IMM_ADD:  exec_ctrl = alu_ctrl(ALU_ADD, 1'b1);
                    IMM_ADDC: exec_ctrl = alu_ctrl(ALU_ADDC, 1'b1);
                    IMM_SUB:  exec_ctrl = alu_ctrl(ALU_SUB, 1'b1);
                    IMM_SUBC: exec_ctrl = alu_ctrl(ALU_SUBC, 1'b1);
                    IMM_CMP:  exec_ctrl = alu_ctrl(ALU_CMP, 1'b1);
                    IMM_MOV:  exec_ctrl = alu_ctrl(ALU_MOV, 1'b1);
                    IMM_LD: begin
                        exec_ctrl.rf_wr    = 1'b1;
                        exec_ctrl.rf_src   = RF_SCR;
                        exec_ctrl.scr_addr = SCR_IMM;
                    end
                    IMM_ST: begin
                        exec_ctrl.scr_we   = 1'b1;
                        exec_ctrl.scr_addr = SCR_IMM;
                    end
                    default: illegal = 1'b1;
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/ctrl_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_sequencer (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               intr,
    input  cu_pkg::ctrl_word_t exec_ctrl,
    input  logic               illegal,
    output cu_pkg::ctrl_word_t ctrl
);
    import cu_pkg::*;

    typedef enum logic [1:0] {
        ST_INIT  = 2'd0,
        ST_FETCH = 2'd1,
        ST_EXEC  = 2'd2,
        ST_INTR  = 2'd3
    } state_t;

    state_t state;
    state_t next_state;

    ////////////////////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= ST_INIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            ST_INIT:  next_state = ST_FETCH;
            ST_FETCH: next_state = ST_EXEC;
            ST_EXEC:  next_state = intr ? ST_INTR : ST_FETCH;
            default:  next_state = ST_FETCH;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output word per state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl = CTRL_NONE;
        case (state)
            ST_INIT:  ctrl.rst    = 1'b1;
            ST_FETCH: ctrl.pc_inc = 1'b1;
            ST_EXEC: begin
                ctrl     = exec_ctrl;
                // Unknown opcode resets the datapath
                ctrl.rst = illegal;
            end
            default: begin
                // Push the PC, save flags, jump to the vector
                ctrl.pc_src      = PC_INTR;
                ctrl.pc_ld       = 1'b1;
                ctrl.scr_we      = 1'b1;
                ctrl.scr_data_pc = 1'b1;
                ctrl.scr_addr    = SCR_SP_M1;
                ctrl.sp_decr     = 1'b1;
                ctrl.flg_shad_ld = 1'b1;
                ctrl.i_clr       = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/cpu_control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_control_unit (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               c,
    input  logic               z,
    input  logic               intr,
    input  cu_pkg::opcode_t    opcode,
    output cu_pkg::ctrl_word_t ctrl
);
    import cu_pkg::*;

    ctrl_word_t exec_ctrl;
    logic       illegal;

    ctrl_decode u_decode (
        .opcode    (opcode),
        .c         (c),
        .z         (z),
        .exec_ctrl (exec_ctrl),
        .illegal   (illegal)
    );

    ctrl_sequencer u_sequencer (
        .CLK       (CLK),
        .RESET     (RESET),
        .intr      (intr),
        .exec_ctrl (exec_ctrl),
        .illegal   (illegal),
        .ctrl      (ctrl)
    );

endmodule

`default_nettype wire

// ==== tb/ctrl_sequencer_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_sequencer_assert (
    input logic               CLK,
    input logic               RESET,
    input logic [1:0]         state,
    input cu_pkg::ctrl_word_t ctrl
);
    import cu_pkg::*;

    // Sequencer encoding of fetch
    localparam logic [1:0] ST_FETCH = 2'd1;

    ctrl_word_t fetch_word;

    always_comb begin
        fetch_word        = CTRL_NONE;
        fetch_word.pc_inc = 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Mutually exclusive controls
    ////////////////////////////////////////////////////////////////////////////

    assert property (@(posedge CLK) disable iff (RESET) !(ctrl.pc_inc && ctrl.pc_ld))
        else $error("pc_inc and pc_ld active together");
    assert property (@(posedge CLK) disable iff (RESET) !(ctrl.sp_incr && ctrl.sp_decr))
        else $error("sp_incr and sp_decr active together");
    assert property (@(posedge CLK) disable iff (RESET) !(ctrl.i_set && ctrl.i_clr))
        else $error("i_set and i_clr active together");
    assert property (@(posedge CLK) disable iff (RESET) !(ctrl.flg_c_set && ctrl.flg_c_clr))
        else $error("flg_c_set and flg_c_clr active together");

    // Fetch only advances the program counter
    assert property (@(posedge CLK) disable iff (RESET)
        (state == ST_FETCH) |-> (ctrl == fetch_word))
        else $error("fetch cycle carries controls other than pc_inc");

endmodule

`default_nettype wire

// ==== tb/tb_cpu_control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_control_unit;
    import cu_pkg::*;

    localparam int N_EXEC = 2000;
    // Fetch plus execute, and an interrupt cycle about one time in eight
    localparam int MAX_CYCLES = N_EXEC * 5 / 2;

    localparam int M_FETCH = 0;
    localparam int M_EXEC  = 1;
    localparam int M_INTR  = 2;

    logic       CLK = 1'b0;
    logic       RESET;
    logic       c;
    logic       z;
    logic       intr;
    opcode_t    opcode;
    ctrl_word_t ctrl;

    integer seed;
    int     cycle_count = 0;
    int     exec_count  = 0;
    int     exp_state;
    opcode_t cur_op;
    logic    cur_c;
    logic    cur_z;
    logic    cur_intr;

    opcode_t rr_alu_ops [15] = '{OP_AND, OP_OR, OP_EXOR, OP_TEST, OP_ADD, OP_ADDC, OP_SUB,
        OP_SUBC, OP_CMP, OP_MOV, OP_LSL, OP_LSR, OP_ROL, OP_ROR, OP_ASR};
    alu_op_t rr_alu_fn [15] = '{ALU_AND, ALU_OR, ALU_EXOR, ALU_TEST, ALU_ADD, ALU_ADDC,
        ALU_SUB, ALU_SUBC, ALU_CMP, ALU_MOV, ALU_LSL, ALU_LSR, ALU_ROL, ALU_ROR, ALU_ASR};
    logic [4:0] imm_alu_pfx [10] = '{IMM_AND, IMM_OR, IMM_EXOR, IMM_TEST, IMM_ADD, IMM_ADDC,
        IMM_SUB, IMM_SUBC, IMM_CMP, IMM_MOV};
    alu_op_t imm_alu_fn [10] = '{ALU_AND, ALU_OR, ALU_EXOR, ALU_TEST, ALU_ADD, ALU_ADDC,
        ALU_SUB, ALU_SUBC, ALU_CMP, ALU_MOV};
    opcode_t misc_ops [18] = '{OP_BRN, OP_CALL, OP_BREQ, OP_BRNE, OP_BRCS, OP_BRCC, OP_LD,
        OP_ST, OP_PUSH, OP_POP, OP_WSP, OP_CLC, OP_SEC, OP_RET, OP_SEI, OP_CLI, OP_RETID,
        OP_RETIE};
    // Codes outside the instruction table
    opcode_t unused_ops [10] = '{7'h0C, 7'h17, 7'h1F, 7'h27, 7'h29, 7'h33, 7'h3C, 7'h64,
        7'h6B, 7'h7A};

    cpu_control_unit uut (
        .CLK    (CLK),
        .RESET  (RESET),
        .c      (c),
        .z      (z),
        .intr   (intr),
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    bind ctrl_sequencer ctrl_sequencer_assert u_seq_assert (
        .CLK   (CLK),
        .RESET (RESET),
        .state (state),
        .ctrl  (ctrl)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("RESULT: FAIL");
            $fatal(1, "Timeout: %0d execute cycles done after %0d clock cycles",
                   exec_count, cycle_count);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic int rand_below(input int n);
        return int'(($random(seed) & 32'h7fff_ffff) % n);
    endfunction

    function automatic opcode_t pick_opcode();
        int k;
        if (rand_below(16) == 0) begin
            return unused_ops[rand_below(10)];
        end
        k = rand_below(45);
        if (k < 15) return rr_alu_ops[k];
        if (k < 33) return misc_ops[k - 15];
        if (k < 43) return {imm_alu_pfx[k - 33], 2'(rand_below(4))};
        return {(k == 43) ? IMM_LD : IMM_ST, 2'(rand_below(4))};
    endfunction

    function automatic ctrl_word_t model_alu(input alu_op_t fn, input logic imm);
        ctrl_word_t w;
        w             = CTRL_NONE;
        w.alu_op      = fn;
        w.alu_opy_imm = imm;
        w.rf_wr       = !(fn inside {ALU_CMP, ALU_TEST});
        if (fn inside {ALU_AND, ALU_OR, ALU_EXOR, ALU_TEST}) begin
            w.flg_c_clr = 1'b1;
            w.flg_z_ld  = 1'b1;
        end else if (fn != ALU_MOV) begin
            w.flg_c_ld = 1'b1;
            w.flg_z_ld = 1'b1;
        end
        return w;
    endfunction

    function automatic ctrl_word_t model_exec(input opcode_t op, input logic cv, input logic zv);
        ctrl_word_t w;
        int         i;
        w = CTRL_NONE;
        for (i = 0; i < 15; i++) begin
            if (op == rr_alu_ops[i]) return model_alu(rr_alu_fn[i], 1'b0);
        end
        for (i = 0; i < 10; i++) begin
            if (op[6:2] == imm_alu_pfx[i]) return model_alu(imm_alu_fn[i], 1'b1);
        end
        if (op[6:2] == IMM_LD || op == OP_LD || op == OP_POP) begin
            w.rf_wr  = 1'b1;
            w.rf_src = RF_SCR;
        end
        if (op[6:2] == IMM_LD || op[6:2] == IMM_ST) begin
            w.scr_we   = (op[6:2] == IMM_ST);
            w.scr_addr = SCR_IMM;
            return w;
        end
        case (op)
            OP_BRN:  w.pc_ld = 1'b1;
            OP_BREQ: w.pc_ld = zv;
            OP_BRNE: w.pc_ld = !zv;
            OP_BRCS: w.pc_ld = cv;
            OP_BRCC: w.pc_ld = !cv;
            OP_CALL, OP_PUSH: begin
                w.pc_ld       = (op == OP_CALL);
                w.scr_data_pc = (op == OP_CALL);
                w.sp_decr     = 1'b1;
                w.scr_we      = 1'b1;
                w.scr_addr    = SCR_SP_M1;
            end
            OP_LD:  w.scr_addr = SCR_REG;
            OP_ST:  w.scr_we   = 1'b1;
            OP_POP: begin
                w.sp_incr  = 1'b1;
                w.scr_addr = SCR_SP;
            end
            OP_WSP: w.sp_ld     = 1'b1;
            OP_SEC: w.flg_c_set = 1'b1;
            OP_CLC: w.flg_c_clr = 1'b1;
            OP_SEI: w.i_set     = 1'b1;
            OP_CLI: w.i_clr     = 1'b1;
            OP_RET, OP_RETID, OP_RETIE: begin
                w.pc_ld    = 1'b1;
                w.pc_src   = PC_STACK;
                w.sp_incr  = 1'b1;
                w.scr_addr = SCR_SP;
            end
            default: w.rst = 1'b1;
        endcase
        // Return from interrupt restores the saved flags
        if (op == OP_RETID || op == OP_RETIE) begin
            w.flg_ld_shadow = 1'b1;
            w.flg_c_ld      = 1'b1;
            w.flg_z_ld      = 1'b1;
            w.i_set         = (op == OP_RETIE);
            w.i_clr         = (op == OP_RETID);
        end
        return w;
    endfunction

    function automatic ctrl_word_t fixed_word(input int st);
        ctrl_word_t w;
        w = CTRL_NONE;
        if (st == M_FETCH) begin
            w.pc_inc = 1'b1;
        end else if (st == M_INTR) begin
            w.pc_ld       = 1'b1;
            w.pc_src      = PC_INTR;
            w.scr_we      = 1'b1;
            w.scr_data_pc = 1'b1;
            w.scr_addr    = SCR_SP_M1;
            w.sp_decr     = 1'b1;
            w.flg_shad_ld = 1'b1;
            w.i_clr       = 1'b1;
        end else begin
            w.rst = 1'b1;
        end
        return w;
    endfunction

    task automatic check_word(input string name, input ctrl_word_t expected,
                              input ctrl_word_t actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Control word mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed   = 32'ha279_292f;
        RESET  = 1'b1;
        c      = 1'b0;
        z      = 1'b0;
        intr   = 1'b0;
        opcode = '0;

        repeat (3) begin
            @(posedge CLK);
            @(negedge CLK);
            check_word("reset", fixed_word(-1), ctrl);
        end
        @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        check_word("init after reset", fixed_word(-1), ctrl);

        exp_state = M_FETCH;
        while (exec_count < N_EXEC) begin
            @(posedge CLK);
            cur_c    = 1'(rand_below(2));
            cur_z    = 1'(rand_below(2));
            cur_op   = (exp_state == M_EXEC) ? pick_opcode() : 7'(rand_below(128));
            cur_intr = (exp_state == M_EXEC) && (rand_below(8) == 0);
            c      <= cur_c;
            z      <= cur_z;
            opcode <= cur_op;
            intr   <= cur_intr;
            @(negedge CLK);
            if (exp_state == M_EXEC) begin
                check_word($sformatf("execute op %02h c %0b z %0b", cur_op, cur_c, cur_z),
                           model_exec(cur_op, cur_c, cur_z), ctrl);
                exec_count++;
                exp_state = cur_intr ? M_INTR : M_FETCH;
            end else begin
                check_word((exp_state == M_FETCH) ? "fetch" : "interrupt",
                           fixed_word(exp_state), ctrl);
                exp_state = (exp_state == M_FETCH) ? M_EXEC : M_FETCH;
            end
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
source/cu_pkg.sv
source/ctrl_decode.sv
source/ctrl_sequencer.sv
source/cpu_control_unit.sv
tb/ctrl_sequencer_assert.sv
tb/tb_cpu_control_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_cpu_control_unit \
    --Mdir obj_dir -o sim_cpu_control_unit \
    -f project.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_cpu_control_unit
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
